// File: glb_subsys.f
source/glb_pkg.sv
source/wb_pkg.sv
source/sram_bank.sv
source/glb_bank_array.sv
source/wb_glb_port.sv
source/glb_top.sv
testbench/tb_clkgen.sv
testbench/glb_top_asserts.sv
testbench/glb_top_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module glb_top_tb \
    --Mdir obj_dir -o glb_sim \
    -f glb_subsys.f

out=$(./obj_dir/glb_sim)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// File: source/glb_bank_array.sv
`timescale 1ns/1ps

// word-interleaved bank array
// needs two or more banks, bank index is taken from the low address bits
module glb_bank_array #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 256
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  glb_pkg::glb_req_t          req,
    output logic [glb_pkg::DATA_W-1:0] rdata
);

    import glb_pkg::*;

    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int ROW_W  = $clog2(BANK_WORDS);

    logic [BANK_W-1:0] bank_idx;
    logic [ROW_W-1:0]  row;
    logic [BANK_W-1:0] rd_sel_q;            // bank of the latest read
    logic [DATA_W-1:0] bank_dout [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_rd;
    logic [NUM_BANKS-1:0] bank_wr;

    assign bank_idx = req.addr[BANK_W-1:0];
    assign row      = req.addr[BANK_W +: ROW_W];

    // strobes only reach the addressed bank
    always_comb begin
        bank_rd = '0;
        bank_wr = '0;
        bank_rd[bank_idx] = req.rd;
        bank_wr[bank_idx] = req.wr;
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_bank #(
            .WORDS    (BANK_WORDS)
        ) u_bank (
            .clk      (clk),
            .rst_n    (rst_n),
            .addr_r   (row),
            .addr_w   (row),
            .read_en  (bank_rd[b]),
            .write_en (bank_wr[b]),
            .data_in  (req.wdata),
            .data_out (bank_dout[b])
        );
    end

    // writes leave the select alone, so a write to another bank
    // cannot disturb the returned word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel_q <= '0;
        end else if (req.rd) begin
            rd_sel_q <= bank_idx;
        end
    end

    assign rdata = bank_dout[rd_sel_q];

endmodule

// File: source/glb_pkg.sv
package glb_pkg;

    // bus word and address geometry
    localparam int DATA_W = 32;
    localparam int ADDR_W = 12;             // word address, not byte address

    // default storage layout, overridden from the top level
    localparam int DEF_NUM_BANKS  = 4;
    localparam int DEF_BANK_WORDS = 256;

    // one access into the bank array
    // rd and wr are single-cycle strobes and never high together
    typedef struct packed {
        logic [ADDR_W-1:0] addr;            // low bits pick the bank
        logic [DATA_W-1:0] wdata;
        logic              rd;
        logic              wr;
    } glb_req_t;

endpackage

// File: source/glb_top.sv
`timescale 1ns/1ps

// global buffer subsystem
// host wishbone port on one side, interleaved banks behind it
module glb_top #(
    parameter int NUM_BANKS  = glb_pkg::DEF_NUM_BANKS,
    parameter int BANK_WORDS = glb_pkg::DEF_BANK_WORDS
) (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_m2s_t wb_i,
    output wb_pkg::wb_s2m_t wb_o
);

    import glb_pkg::*;

    glb_req_t          bank_req;            // one strobe per accepted request
    logic [DATA_W-1:0] bank_rdata;          // held word of the last read

    // bus side: decode, range check and response
    wb_glb_port #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) u_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_i       (wb_i),
        .wb_o       (wb_o),
        .req        (bank_req),
        .rdata      (bank_rdata)
    );

    // storage side
    glb_bank_array #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) u_banks (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (bank_req),
        .rdata      (bank_rdata)
    );

endmodule

// File: source/sram_bank.sv
`timescale 1ns/1ps

// single-port bank with one cycle read latency
// the output is held after the read cycle until the next read
module sram_bank #(
    parameter int  WORDS = 256,
    localparam int ROW_W = $clog2(WORDS)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [ROW_W-1:0]           addr_r,
    input  logic [ROW_W-1:0]           addr_w,
    input  logic                       read_en,
    input  logic                       write_en,
    input  logic [glb_pkg::DATA_W-1:0] data_in,
    output logic [glb_pkg::DATA_W-1:0] data_out
);

    import glb_pkg::*;

    logic [DATA_W-1:0] mem [WORDS];
    logic [DATA_W-1:0] mem_q;               // raw array output
    logic [DATA_W-1:0] hold_q;
    logic              read_en_d;
    logic [ROW_W-1:0]  row;

    // array powers up cleared
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // one shared address, write wins like the macro port
    assign row = write_en ? addr_w : addr_r;

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[row] <= data_in;
        end else if (read_en) begin
            mem_q <= mem[row];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_en_d <= 1'b0;
        end else begin
            read_en_d <= read_en && !write_en;
        end
    end

    // capture the fresh word in the cycle it appears
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q <= '0;
        end else if (read_en_d) begin
            hold_q <= mem_q;
        end
    end

    assign data_out = read_en_d ? mem_q : hold_q;

endmodule

// File: source/wb_glb_port.sv
`timescale 1ns/1ps

// wishbone classic slave in front of the bank array
// write acks one cycle after accept, read acks two cycles after,
// out of range ends with err and never reaches a bank
module wb_glb_port #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 256
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  wb_pkg::wb_m2s_t            wb_i,
    output wb_pkg::wb_s2m_t            wb_o,
    output glb_pkg::glb_req_t          req,
    input  logic [glb_pkg::DATA_W-1:0] rdata
);

    import glb_pkg::*;

    localparam int CAPACITY = NUM_BANKS * BANK_WORDS;

    logic              in_range;
    logic              idle;
    logic              accept;
    logic              rd_pend;             // waiting on the bank read latency
    logic              ack_q;
    logic              err_q;
    logic [DATA_W-1:0] dat_q;

    assign in_range = 32'(wb_i.adr) < CAPACITY;

    // busy while a read is in flight or a response is on the bus,
    // so a held stb is not taken a second time
    assign idle   = !rd_pend && !ack_q && !err_q;
    assign accept = wb_i.cyc && wb_i.stb && idle;

    always_comb begin
        req.addr  = wb_i.adr;
        req.wdata = wb_i.dat;
        req.rd    = accept && in_range && !wb_i.we;
        req.wr    = accept && in_range && wb_i.we;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            rd_pend <= req.rd;
            ack_q   <= req.wr || (rd_pend && wb_i.cyc);   // read ack dropped on abort
            err_q   <= accept && !in_range;
        end
    end

    // bank output is valid the cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dat_q <= '0;
        end else if (rd_pend && wb_i.cyc) begin
            dat_q <= rdata;
        end
    end

    always_comb begin
        wb_o.ack = ack_q;
        wb_o.err = err_q;
        wb_o.dat = dat_q;
    end

endmodule

// File: source/wb_pkg.sv
package wb_pkg;

    // wishbone classic, master side outputs
    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [glb_pkg::ADDR_W-1:0] adr;   // word address
        logic [glb_pkg::DATA_W-1:0] dat;   // write data
    } wb_m2s_t;

    // wishbone classic, slave side outputs
    typedef struct packed {
        logic                      ack;
        logic                      err;    // address outside the buffer
        logic [glb_pkg::DATA_W-1:0] dat;   // read data, held until next read ack
    } wb_s2m_t;

endpackage

// File: testbench/glb_top_asserts.sv
`timescale 1ns/1ps

// wishbone handshake and bank strobe rules bound into glb_top
module glb_top_asserts (
    input logic              clk,
    input logic              rst_n,
    input wb_pkg::wb_m2s_t   wb_i,
    input wb_pkg::wb_s2m_t   wb_o,
    input glb_pkg::glb_req_t req
);

    logic resp;                             // any response on the bus

    assign resp = wb_o.ack || wb_o.err;

    a_ack_err_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_o.ack && wb_o.err))
        else $error("ack and err high in the same cycle");

    // one response cycle per request
    a_resp_single: assert property (@(posedge clk) disable iff (!rst_n)
        resp |=> !resp)
        else $error("ack or err held for more than one cycle");

    // one bank strobe cycle per accepted request
    a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        (req.rd || req.wr) |=> !(req.rd || req.wr))
        else $error("bank strobe high for more than one cycle");

    a_no_resp_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !wb_i.cyc |-> !resp)
        else $error("ack or err while cyc is low");

endmodule

bind glb_top glb_top_asserts u_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .wb_i  (wb_i),
    .wb_o  (wb_o),
    .req   (bank_req)
);

// File: testbench/glb_top_tb.sv
`timescale 1ns/1ps

module glb_top_tb;

    import glb_pkg::*;
    import wb_pkg::*;

    localparam int NUM_BANKS  = DEF_NUM_BANKS;
    localparam int BANK_WORDS = DEF_BANK_WORDS;
    localparam int CAPACITY   = NUM_BANKS * BANK_WORDS;
    localparam int ADDR_SPAN  = 1 << ADDR_W;
    localparam int TIMEOUT    = 20;        // cycles allowed for ack or err
    localparam int N_WR       = 40;
    localparam int N_MIX      = 300;

    logic    clk;
    logic    rst_n;
    wb_m2s_t wb_i;
    wb_s2m_t wb_o;

    logic [DATA_W-1:0] model [int];         // reference memory where absent words read as zero
    logic [DATA_W-1:0] last_dat;            // value dat should be holding
    int                errors;
    int                err_base;
    int                tests_passed;
    int                tests_failed;
    logic              timed_out;

    // outcome of the last bus access
    logic              got_ack;
    logic              got_err;
    logic [DATA_W-1:0] got_dat;
    int                got_cycles;

    tb_clkgen #(
        .HALF_PERIOD (20)
    ) u_clk (
        .clk (clk)
    );

    glb_top uut (
        .clk   (clk),
        .rst_n (rst_n),
        .wb_i  (wb_i),
        .wb_o  (wb_o)
    );

    function automatic logic [DATA_W-1:0] model_value(input int adr);
        if (model.exists(adr)) begin
            return model[adr];
        end else begin
            return '0;
        end
    endfunction

    task automatic note_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // called and returns just after a falling edge
    task automatic bus_access(input logic we, input int adr, input logic [DATA_W-1:0] wdat);
        if (timed_out) begin
            return;
        end
        wb_i.cyc   = 1'b1;
        wb_i.stb   = 1'b1;
        wb_i.we    = we;
        wb_i.adr   = ADDR_W'(adr);
        wb_i.dat   = wdat;
        got_cycles = 0;
        got_ack    = 1'b0;
        got_err    = 1'b0;
        while (!(got_ack || got_err) && got_cycles < TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            got_cycles++;
            got_ack = wb_o.ack;
            got_err = wb_o.err;
        end
        if (!(got_ack || got_err)) begin
            $display("timeout at %0t: no ack or err within %0d cycles for adr %0h",
                     $time, TIMEOUT, adr);
            timed_out = 1'b1;
            errors++;
            wb_i.cyc = 1'b0;
            wb_i.stb = 1'b0;
            wb_i.we  = 1'b0;
        end else begin
            got_dat = wb_o.dat;
            @(posedge clk);                 // request stays up through the response edge
            @(negedge clk);
            wb_i.cyc = 1'b0;
            wb_i.stb = 1'b0;
            wb_i.we  = 1'b0;
        end
    endtask

    task automatic write_word(input int adr, input logic [DATA_W-1:0] data);
        bus_access(1'b1, adr, data);
        if (timed_out) begin
            return;
        end
        if (adr < CAPACITY) begin
            if (!got_ack) begin
                note_error($sformatf("write to %0h at %0t ended with err instead of ack",
                                     adr, $time));
            end
            model[adr] = data;
        end else if (!got_err) begin
            note_error($sformatf("out of range write to %0h at %0t was acked", adr, $time));
        end
        if (got_dat !== last_dat) begin
            note_error($sformatf(
                "mismatch at %0t: dat changed on write to %0h, expected %h got %h",
                $time, adr, last_dat, got_dat));
        end
    endtask

    task automatic read_check(input int adr);
        logic [DATA_W-1:0] expected;
        bus_access(1'b0, adr, '0);
        if (timed_out) begin
            return;
        end
        if (adr < CAPACITY) begin
            expected = model_value(adr);
            if (!got_ack) begin
                note_error($sformatf("read of %0h at %0t ended with err instead of ack",
                                     adr, $time));
            end else if (got_dat !== expected) begin
                note_error($sformatf("mismatch at %0t: read adr %0h expected %h got %h",
                                     $time, adr, expected, got_dat));
            end
            last_dat = expected;
        end else begin
            if (!got_err) begin
                note_error($sformatf("out of range read of %0h at %0t was acked", adr, $time));
            end else if (got_dat !== last_dat) begin
                note_error($sformatf(
                    "mismatch at %0t: dat changed on err at %0h, expected %h got %h",
                    $time, adr, last_dat, got_dat));
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == err_base) begin
            tests_passed++;
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, errors - err_base);
        end
        err_base = errors;
    endtask

    task automatic test_reset_state();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (wb_o.ack || wb_o.err) begin
                note_error($sformatf("ack or err high while idle after reset at %0t", $time));
            end
        end
        if (wb_o.dat !== '0) begin
            note_error($sformatf("mismatch at %0t: dat after reset expected 0 got %h",
                                 $time, wb_o.dat));
        end
        for (int i = 0; i < 8; i++) begin
            read_check($urandom_range(CAPACITY - 1, 0));   // model still empty
        end
        finish_test("reset_state");
    endtask

    task automatic test_write_read();
        int addrs [N_WR];
        int j;
        int tmp;
        for (int i = 0; i < N_WR; i++) begin
            addrs[i] = $urandom_range(CAPACITY - 1, 0);
            write_word(addrs[i], $urandom());
            idle_cycles($urandom_range(2, 0));
        end
        for (int i = N_WR - 1; i > 0; i--) begin  // shuffle the read order
            j        = $urandom_range(i, 0);
            tmp      = addrs[i];
            addrs[i] = addrs[j];
            addrs[j] = tmp;
        end
        for (int i = 0; i < N_WR; i++) begin
            read_check(addrs[i]);
        end
        finish_test("write_read");
    endtask

    task automatic test_interleave();
        int base;
        int a_rd;
        base = $urandom_range(BANK_WORDS - 3, 0) * NUM_BANKS;   // two whole rows
        for (int i = 0; i < 2 * NUM_BANKS; i++) begin
            write_word(base + i, {16'($urandom()), 16'(i)});
        end
        for (int i = 0; i < 2 * NUM_BANKS; i++) begin
            read_check(base + i);
        end
        // write one bank then read its neighbour in the same row
        for (int b = 0; b < NUM_BANKS; b++) begin
            a_rd = base + (b + 1) % NUM_BANKS;
            write_word(base + b, ~model_value(base + b));
            read_check(a_rd);
        end
        finish_test("interleave");
    endtask

    task automatic test_hold_latency();
        int a;
        a = $urandom_range(CAPACITY - 1, 0);
        write_word(a, $urandom());
        if (got_cycles != 1) begin
            note_error($sformatf("mismatch at %0t: write ack latency expected 1 got %0d",
                                 $time, got_cycles));
        end
        read_check(a);
        if (got_cycles != 2) begin
            note_error($sformatf("mismatch at %0t: read ack latency expected 2 got %0d",
                                 $time, got_cycles));
        end
        write_word(a ^ 1, $urandom());              // other bank
        write_word(a ^ NUM_BANKS, $urandom());      // same bank in the next row
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            if (wb_o.dat !== last_dat) begin
                note_error($sformatf("mismatch at %0t: held dat expected %h got %h",
                                     $time, last_dat, wb_o.dat));
            end
        end
        finish_test("hold_latency");
    endtask

    task automatic test_out_of_range();
        int a;
        for (int i = 0; i < 12; i++) begin
            if (i == 0) begin
                a = CAPACITY;
            end else if (i == 1) begin
                a = ADDR_SPAN - 1;
            end else begin
                a = $urandom_range(ADDR_SPAN - 1, CAPACITY);
            end
            if ($urandom_range(1, 0) == 1) begin
                write_word(a, $urandom());
            end else begin
                read_check(a);
            end
            if (got_cycles != 1) begin
                note_error($sformatf("mismatch at %0t: err latency expected 1 got %0d",
                                     $time, got_cycles));
            end
            read_check(a % CAPACITY);               // aliased word must be untouched
        end
        finish_test("out_of_range");
    endtask

    task automatic test_random_mix();
        int a;
        for (int i = 0; i < N_MIX; i++) begin
            if ($urandom_range(9, 0) < 8) begin
                a = $urandom_range(CAPACITY - 1, 0);
            end else begin
                a = $urandom_range(ADDR_SPAN - 1, CAPACITY);
            end
            if ($urandom_range(1, 0) == 1) begin
                write_word(a, $urandom());
            end else begin
                read_check(a);
            end
            idle_cycles($urandom_range(3, 0));
        end
        finish_test("random_mix");
    endtask

    initial begin
        void'($urandom(32'hf84a5d87));
        rst_n        = 1'b0;
        wb_i         = '0;
        last_dat     = '0;
        errors       = 0;
        err_base     = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset_state();
        test_write_read();
        test_interleave();
        test_hold_latency();
        test_out_of_range();
        test_random_mix();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (!timed_out && tests_failed == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps

// free running testbench clock, 40 ns period by default
module tb_clkgen #(
    parameter int HALF_PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule
